// File: bench/tb_debug_monitor.sv
// Table-driven testbench for the debug monitor with core model, Wishbone tasks and checks
module tb_debug_monitor;

  import debug_monitor_pkg::*;

  localparam int CLK_PERIOD     = 100;
  localparam int DRIVE_DELAY    = 10;
  localparam int RESET_CYCLES   = 8;
  localparam int NUM_ROWS       = 11;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + RESET_CYCLES;
  localparam int ACK_LIMIT      = 8;
  localparam logic [XLEN-1:0] NOP_OPCODE = 32'h0000_0013;

  // Control column bit 0 is trigger enable, bit 1 ebreakm and bit 2 step
  localparam logic [2:0] C_OFF  = 3'b000;
  localparam logic [2:0] C_TRIG = 3'b001;
  localparam logic [2:0] C_EBM  = 3'b010;
  localparam logic [2:0] C_STEP = 3'b100;

  logic            cov_assert_if;
  logic            arst_n_i;
  logic            wb_valid_i;
  logic            wb_err_i;
  logic [XLEN-1:0] wb_instr_i;
  logic [XLEN-1:0] wb_pc_i;
  logic [XLEN-1:0] wb_next_pc_i;
  logic            id_valid_i;
  logic            debug_req_i;
  logic            debug_mode_i;
  logic            wbs_cyc_i;
  logic            wbs_stb_i;
  logic            wbs_we_i;
  logic [2:0]      wbs_adr_i;
  logic [XLEN-1:0] wbs_dat_i;
  logic [XLEN-1:0] wbs_dat_o;
  logic            wbs_ack_o;

  // Stimulus and expected-value table
  logic [2:0]      tbl_ctrl    [NUM_ROWS];
  logic [XLEN-1:0] tbl_trig    [NUM_ROWS];
  logic [XLEN-1:0] tbl_instr   [NUM_ROWS];
  logic [XLEN-1:0] tbl_pc      [NUM_ROWS];
  logic [XLEN-1:0] tbl_next_pc [NUM_ROWS];
  logic            tbl_err     [NUM_ROWS];
  logic            tbl_req     [NUM_ROWS];
  logic [2:0]      tbl_cause   [NUM_ROWS];
  logic [XLEN-1:0] tbl_dpc     [NUM_ROWS];

  integer          seed;
  int              row_cnt;
  int              test_errors;
  int              pass_cnt;
  int              fail_cnt;
  int              cycle_cnt;
  int              entry_cnt;
  logic [XLEN-1:0] exp_ebreak_pc;

  debug_monitor_top i_dut (
    .cov_assert_if (cov_assert_if),
    .arst_n_i      (arst_n_i),
    .wb_valid_i    (wb_valid_i),
    .wb_err_i      (wb_err_i),
    .wb_instr_i    (wb_instr_i),
    .wb_pc_i       (wb_pc_i),
    .wb_next_pc_i  (wb_next_pc_i),
    .id_valid_i    (id_valid_i),
    .debug_req_i   (debug_req_i),
    .debug_mode_i  (debug_mode_i),
    .wbs_cyc_i     (wbs_cyc_i),
    .wbs_stb_i     (wbs_stb_i),
    .wbs_we_i      (wbs_we_i),
    .wbs_adr_i     (wbs_adr_i),
    .wbs_dat_i     (wbs_dat_i),
    .wbs_dat_o     (wbs_dat_o),
    .wbs_ack_o     (wbs_ack_o)
  );

  initial begin
    cov_assert_if = 1'b0;
    forever #(CLK_PERIOD / 2) cov_assert_if = ~cov_assert_if;
  end

  // Hang guard
  always @(posedge cov_assert_if) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Table helpers and checks
  // --------------------------------------------------
  task automatic add_row(input logic [2:0] ctrl, input logic [XLEN-1:0] trig,
                         input logic [XLEN-1:0] instr, input logic [XLEN-1:0] pc,
                         input logic [XLEN-1:0] next_pc, input logic err, input logic req,
                         input dbg_cause_e cause, input logic [XLEN-1:0] dpc);
    tbl_ctrl[row_cnt]    = ctrl;
    tbl_trig[row_cnt]    = trig;
    tbl_instr[row_cnt]   = instr;
    tbl_pc[row_cnt]      = pc;
    tbl_next_pc[row_cnt] = next_pc;
    tbl_err[row_cnt]     = err;
    tbl_req[row_cnt]     = req;
    tbl_cause[row_cnt]   = cause;
    tbl_dpc[row_cnt]     = dpc;
    row_cnt++;
  endtask

  task automatic fill_table();
    add_row(C_EBM, 32'h0, EBREAK_OPCODE, 32'h100, 32'h104, 0, 0, CAUSE_EBREAK, 32'h100);
    add_row(C_EBM, 32'h0, CEBREAK_OPCODE, 32'h200, 32'h202, 0, 0, CAUSE_EBREAK, 32'h200);
    // ebreak without ebreakm just retires
    add_row(C_OFF, 32'h0, EBREAK_OPCODE, 32'h300, 32'h304, 0, 0, CAUSE_NONE, 32'h304);
    add_row(C_OFF, 32'h0, NOP_OPCODE, 32'h304, 32'h308, 0, 1, CAUSE_HALTREQ, 32'h308);
    add_row(C_TRIG, 32'h400, NOP_OPCODE, 32'h400, 32'h404, 0, 1, CAUSE_TRIGGER, 32'h400);
    add_row(C_OFF, 32'h400, NOP_OPCODE, 32'h400, 32'h404, 0, 1, CAUSE_HALTREQ, 32'h404);
    // Unaligned trigger address still matches the word
    add_row(C_TRIG, 32'h502, NOP_OPCODE, 32'h500, 32'h504, 0, 0, CAUSE_TRIGGER, 32'h500);
    add_row(C_STEP, 32'h0, NOP_OPCODE, 32'h600, 32'h604, 0, 0, CAUSE_STEP, 32'h604);
    // Erroneous retirement keeps the step entry results
    add_row(C_EBM, 32'h0, EBREAK_OPCODE, 32'h700, 32'h704, 1, 0, CAUSE_STEP, 32'h604);
    add_row(C_TRIG | C_EBM, 32'h800, EBREAK_OPCODE, 32'h800, 32'h804, 0, 1, CAUSE_TRIGGER,
            32'h800);
    add_row(C_EBM, 32'h800, EBREAK_OPCODE, 32'h900, 32'h904, 0, 1, CAUSE_EBREAK, 32'h900);
  endtask

  task automatic check_value(input string what, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      pass_cnt++;
      $display("Test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("Test %s: failed with %0d errors", name, test_errors);
    end
  endtask

  // --------------------------------------------------
  // Wishbone master
  // --------------------------------------------------
  task automatic await_ack();
    int waited;
    waited = 0;
    do begin
      @(posedge cov_assert_if);
      #DRIVE_DELAY;
      waited++;
    end while (!wbs_ack_o && waited < ACK_LIMIT);
    assert (wbs_ack_o) else begin
      $display("Wishbone slave gave no ack within %0d cycles at %0t", ACK_LIMIT, $time);
      test_errors++;
    end
  endtask

  task automatic write_reg(input logic [2:0] adr, input logic [XLEN-1:0] data);
    @(posedge cov_assert_if);
    #DRIVE_DELAY;
    wbs_cyc_i = 1'b1;
    wbs_stb_i = 1'b1;
    wbs_we_i  = 1'b1;
    wbs_adr_i = adr;
    wbs_dat_i = data;
    await_ack();
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_we_i  = 1'b0;
  endtask

  task automatic read_reg(input logic [2:0] adr, output logic [XLEN-1:0] data);
    @(posedge cov_assert_if);
    #DRIVE_DELAY;
    wbs_cyc_i = 1'b1;
    wbs_stb_i = 1'b1;
    wbs_we_i  = 1'b0;
    wbs_adr_i = adr;
    await_ack();
    data      = wbs_dat_o;
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
  endtask

  // --------------------------------------------------
  // Core model
  // --------------------------------------------------
  task automatic retire_instr(input logic [XLEN-1:0] instr, input logic [XLEN-1:0] pc,
                              input logic [XLEN-1:0] next_pc, input logic err,
                              input logic req);
    @(posedge cov_assert_if);
    #DRIVE_DELAY;
    wb_valid_i   = 1'b1;
    wb_err_i     = err;
    wb_instr_i   = instr;
    wb_pc_i      = pc;
    wb_next_pc_i = next_pc;
    debug_req_i  = req;
    @(posedge cov_assert_if);
    #DRIVE_DELAY;
    wb_valid_i  = 1'b0;
    wb_err_i    = 1'b0;
    debug_req_i = 1'b0;
  endtask

  // Halt, decode and retire one debug instruction, then resume
  task automatic enter_and_leave_debug();
    logic [XLEN-1:0] filler;
    filler      = $random(seed);
    filler[1:0] = 2'b00;
    @(posedge cov_assert_if);
    #DRIVE_DELAY;
    debug_mode_i = 1'b1;
    id_valid_i   = 1'b1;
    @(posedge cov_assert_if);
    #DRIVE_DELAY;
    id_valid_i   = 1'b0;
    wb_valid_i   = 1'b1;
    wb_instr_i   = NOP_OPCODE;
    wb_pc_i      = filler;
    wb_next_pc_i = filler + 32'd4;
    @(posedge cov_assert_if);
    #DRIVE_DELAY;
    wb_valid_i   = 1'b0;
    debug_mode_i = 1'b0;
    entry_cnt++;
  endtask

  task automatic run_row(input int r);
    logic [XLEN-1:0] got;
    logic [XLEN-1:0] ctrl_word;
    logic [XLEN-1:0] exp_status;
    test_errors = 0;
    ctrl_word   = '0;
    ctrl_word[CTRL_TRIG_EN_POS] = tbl_ctrl[r][0];
    ctrl_word[CTRL_EBREAKM_POS] = tbl_ctrl[r][1];
    ctrl_word[CTRL_STEP_POS]    = tbl_ctrl[r][2];
    write_reg(REG_CTRL, ctrl_word);
    write_reg(REG_TRIG_ADDR, tbl_trig[r]);
    read_reg(REG_CTRL, got);
    check_value("control", got, ctrl_word);
    retire_instr(tbl_instr[r], tbl_pc[r], tbl_next_pc[r], tbl_err[r], tbl_req[r]);
    if (!tbl_err[r] && (tbl_instr[r] == EBREAK_OPCODE || tbl_instr[r] == CEBREAK_OPCODE)) begin
      exp_ebreak_pc = tbl_pc[r];
    end
    enter_and_leave_debug();
    exp_status = 32'(tbl_cause[r]) | (32'(entry_cnt) << STATUS_CNT_LSB);
    read_reg(REG_STATUS, got);
    check_value("status", got, exp_status);
    read_reg(REG_DPC, got);
    check_value("dpc", got, tbl_dpc[r]);
    read_reg(REG_EBREAK_PC, got);
    check_value("ebreak pc", got, exp_ebreak_pc);
    end_test($sformatf("row %0d", r));
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    logic [XLEN-1:0] got;
    arst_n_i      = 1'b0;
    wb_valid_i    = 1'b0;
    wb_err_i      = 1'b0;
    wb_instr_i    = '0;
    wb_pc_i       = '0;
    wb_next_pc_i  = '0;
    id_valid_i    = 1'b0;
    debug_req_i   = 1'b0;
    debug_mode_i  = 1'b0;
    wbs_cyc_i     = 1'b0;
    wbs_stb_i     = 1'b0;
    wbs_we_i      = 1'b0;
    wbs_adr_i     = '0;
    wbs_dat_i     = '0;
    seed          = 24;
    row_cnt       = 0;
    pass_cnt      = 0;
    fail_cnt      = 0;
    cycle_cnt     = 0;
    entry_cnt     = 0;
    exp_ebreak_pc = '0;
    fill_table();

    repeat (RESET_CYCLES) @(posedge cov_assert_if);
    #DRIVE_DELAY;
    arst_n_i = 1'b1;

    // Reset values and trigger address write
    test_errors = 0;
    for (int a = 0; a <= REG_EBREAK_PC; a++) begin
      read_reg(3'(a), got);
      check_value($sformatf("register %0d after reset", a), got, '0);
    end
    write_reg(REG_TRIG_ADDR, 32'hDEAD_BEEF);
    read_reg(REG_TRIG_ADDR, got);
    check_value("trigger address", got, 32'hDEAD_BEEC);
    end_test("reset and trigger address");

    for (int r = 0; r < row_cnt; r++) begin
      run_row(r);
    end

    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: debug_monitor.f
logic/debug_monitor_pkg.sv
logic/retire_decoder.sv
logic/cause_tracker.sv
logic/dpc_predictor.sv
logic/entry_detector.sv
logic/wb_status_regs.sv
logic/debug_monitor_top.sv
bench/tb_debug_monitor.sv

// File: logic/cause_tracker.sv
// Prioritized tracker of the expected debug entry cause
module cause_tracker (
  input  logic                                cov_assert_if,
  input  logic                                arst_n_i,
  input  logic                                debug_mode_i,
  input  logic                                debug_req_i,
  input  logic                                retire_i,
  input  debug_monitor_pkg::instr_class_e     instr_class_i,
  input  logic                                trig_hit_i,
  input  logic                                ebreakm_i,
  input  logic                                step_i,
  output debug_monitor_pkg::dbg_cause_e       cause_o
);

  import debug_monitor_pkg::*;

  dbg_cause_e cause_q;
  dbg_cause_e cause_d;
  logic       is_ebreak;
  logic       step_allowed;

  // Both ebreak forms behave the same for entry
  assign is_ebreak = retire_i &&
                     ((instr_class_i == INSTR_EBREAK) || (instr_class_i == INSTR_CEBREAK));

  // Step may not override a stronger pending cause
  assign step_allowed = (cause_q == CAUSE_NONE) || (cause_q == CAUSE_STEP);

  // --------------------------------------------------
  // Fixed priority: trigger, ebreak, haltreq, step
  // --------------------------------------------------
  always_comb begin
    cause_d = cause_q;
    if (trig_hit_i) begin
      cause_d = CAUSE_TRIGGER;
    end else if (ebreakm_i && is_ebreak) begin
      cause_d = CAUSE_EBREAK;
    end else if (debug_req_i) begin
      cause_d = CAUSE_HALTREQ;
    end else if (step_i && step_allowed) begin
      cause_d = CAUSE_STEP;
    end else if (retire_i) begin
      // Nothing pending survives a plain retirement
      cause_d = CAUSE_NONE;
    end
  end

  // Frozen while the core is in debug mode
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cause_q <= CAUSE_NONE;
    end else if (!debug_mode_i) begin
      cause_q <= cause_d;
    end
  end

  assign cause_o = cause_q;

endmodule

// File: logic/debug_monitor_pkg.sv
// Opcodes, widths, register map and the cause and instruction-class enums
package debug_monitor_pkg;

  // --------------------------------------------------
  // Architectural widths
  // --------------------------------------------------
  localparam int XLEN          = 32;
  localparam int PC_ALIGN_BITS = 2;
  localparam int ENTRY_CNT_W   = 8;

  // Instruction encodings seen at writeback
  localparam logic [XLEN-1:0] EBREAK_OPCODE  = 32'h0010_0073;
  localparam logic [XLEN-1:0] CEBREAK_OPCODE = 32'h0000_9002;
  localparam logic [XLEN-1:0] WFI_OPCODE     = 32'h1050_0073;
  localparam logic [XLEN-1:0] DRET_OPCODE    = 32'h7b20_0073;

  // --------------------------------------------------
  // Register map, word addresses
  // --------------------------------------------------
  localparam logic [2:0] REG_CTRL      = 3'd0;
  localparam logic [2:0] REG_TRIG_ADDR = 3'd1;
  localparam logic [2:0] REG_STATUS    = 3'd2;
  localparam logic [2:0] REG_DPC       = 3'd3;
  localparam logic [2:0] REG_EBREAK_PC = 3'd4;

  // Control bits
  localparam int CTRL_TRIG_EN_POS = 0;
  localparam int CTRL_EBREAKM_POS = 1;
  localparam int CTRL_STEP_POS    = 2;

  // Status layout: cause in [2:0], entry count from this bit up
  localparam int STATUS_CNT_LSB = 8;

  typedef enum logic [2:0] {
    INSTR_OTHER,
    INSTR_EBREAK,
    INSTR_CEBREAK,
    INSTR_WFI,
    INSTR_DRET
  } instr_class_e;

  // Same encoding as dcsr.cause
  typedef enum logic [2:0] {
    CAUSE_NONE    = 3'd0,
    CAUSE_EBREAK  = 3'd1,
    CAUSE_TRIGGER = 3'd2,
    CAUSE_HALTREQ = 3'd3,
    CAUSE_STEP    = 3'd4
  } dbg_cause_e;

endpackage

// File: logic/debug_monitor_top.sv
// Debug-entry monitor top level with core and Wishbone ports
module debug_monitor_top (
  input  logic                                cov_assert_if,
  input  logic                                arst_n_i,
  // Core retirement side
  input  logic                                wb_valid_i,
  input  logic                                wb_err_i,
  input  logic [debug_monitor_pkg::XLEN-1:0]  wb_instr_i,
  input  logic [debug_monitor_pkg::XLEN-1:0]  wb_pc_i,
  input  logic [debug_monitor_pkg::XLEN-1:0]  wb_next_pc_i,
  input  logic                                id_valid_i,
  input  logic                                debug_req_i,
  input  logic                                debug_mode_i,
  // Host side
  input  logic                                wbs_cyc_i,
  input  logic                                wbs_stb_i,
  input  logic                                wbs_we_i,
  input  logic [2:0]                          wbs_adr_i,
  input  logic [debug_monitor_pkg::XLEN-1:0]  wbs_dat_i,
  output logic [debug_monitor_pkg::XLEN-1:0]  wbs_dat_o,
  output logic                                wbs_ack_o
);

  import debug_monitor_pkg::*;

  logic            retire;
  instr_class_e    instr_class;
  logic            trig_hit;
  dbg_cause_e      cause;
  logic            first_debug;
  logic            decoded_in_debug;
  logic [XLEN-1:0] dpc;
  logic [XLEN-1:0] ebreak_pc;
  logic            trig_en;
  logic            ebreakm;
  logic            step;
  logic [XLEN-1:0] trig_addr;

  // --------------------------------------------------
  // Retirement decode
  // --------------------------------------------------
  retire_decoder i_retire_decoder (
    .wb_valid_i    (wb_valid_i),
    .wb_err_i      (wb_err_i),
    .wb_instr_i    (wb_instr_i),
    .wb_pc_i       (wb_pc_i),
    .trig_addr_i   (trig_addr),
    .trig_en_i     (trig_en),
    .retire_o      (retire),
    .instr_class_o (instr_class),
    .trig_hit_o    (trig_hit)
  );

  cause_tracker i_cause_tracker (
    .cov_assert_if (cov_assert_if),
    .arst_n_i      (arst_n_i),
    .debug_mode_i  (debug_mode_i),
    .debug_req_i   (debug_req_i),
    .retire_i      (retire),
    .instr_class_i (instr_class),
    .trig_hit_i    (trig_hit),
    .ebreakm_i     (ebreakm),
    .step_i        (step),
    .cause_o       (cause)
  );

  dpc_predictor i_dpc_predictor (
    .cov_assert_if      (cov_assert_if),
    .arst_n_i           (arst_n_i),
    .debug_mode_i       (debug_mode_i),
    .decoded_in_debug_i (decoded_in_debug),
    .retire_i           (retire),
    .instr_class_i      (instr_class),
    .cause_i            (cause),
    .wb_pc_i            (wb_pc_i),
    .wb_next_pc_i       (wb_next_pc_i),
    .dpc_o              (dpc),
    .ebreak_pc_o        (ebreak_pc)
  );

  entry_detector i_entry_detector (
    .cov_assert_if      (cov_assert_if),
    .arst_n_i           (arst_n_i),
    .debug_mode_i       (debug_mode_i),
    .id_valid_i         (id_valid_i),
    .retire_i           (retire),
    .first_debug_o      (first_debug),
    .decoded_in_debug_o (decoded_in_debug)
  );

  // --------------------------------------------------
  // Host register block
  // --------------------------------------------------
  wb_status_regs i_wb_status_regs (
    .cov_assert_if (cov_assert_if),
    .arst_n_i      (arst_n_i),
    .wbs_cyc_i     (wbs_cyc_i),
    .wbs_stb_i     (wbs_stb_i),
    .wbs_we_i      (wbs_we_i),
    .wbs_adr_i     (wbs_adr_i),
    .wbs_dat_i     (wbs_dat_i),
    .first_debug_i (first_debug),
    .cause_i       (cause),
    .dpc_i         (dpc),
    .ebreak_pc_i   (ebreak_pc),
    .wbs_dat_o     (wbs_dat_o),
    .wbs_ack_o     (wbs_ack_o),
    .trig_en_o     (trig_en),
    .ebreakm_o     (ebreakm),
    .step_o        (step),
    .trig_addr_o   (trig_addr)
  );

endmodule

// File: logic/dpc_predictor.sv
// Expected dpc prediction and ebreak pc capture
module dpc_predictor (
  input  logic                                cov_assert_if,
  input  logic                                arst_n_i,
  input  logic                                debug_mode_i,
  input  logic                                decoded_in_debug_i,
  input  logic                                retire_i,
  input  debug_monitor_pkg::instr_class_e     instr_class_i,
  input  debug_monitor_pkg::dbg_cause_e       cause_i,
  input  logic [debug_monitor_pkg::XLEN-1:0]  wb_pc_i,
  input  logic [debug_monitor_pkg::XLEN-1:0]  wb_next_pc_i,
  output logic [debug_monitor_pkg::XLEN-1:0]  dpc_o,
  output logic [debug_monitor_pkg::XLEN-1:0]  ebreak_pc_o
);

  import debug_monitor_pkg::*;

  logic [XLEN-1:0] last_pc_q;
  logic [XLEN-1:0] last_next_pc_q;
  logic [XLEN-1:0] ebreak_pc_q;
  logic            hold;
  logic            is_ebreak;
  logic            use_retire_pc;

  // Debug code already running, keep the entry prediction
  assign hold = debug_mode_i && decoded_in_debug_i;

  assign is_ebreak = retire_i &&
                     ((instr_class_i == INSTR_EBREAK) || (instr_class_i == INSTR_CEBREAK));

  // --------------------------------------------------
  // Last retirement, sampled one edge after it
  // --------------------------------------------------
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_pc_q      <= '0;
      last_next_pc_q <= '0;
    end else if (retire_i && !hold) begin
      last_pc_q      <= wb_pc_i;
      last_next_pc_q <= wb_next_pc_i;
    end
  end

  // Every ebreak is recorded, also inside debug mode
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ebreak_pc_q <= '0;
    end else if (is_ebreak) begin
      ebreak_pc_q <= wb_pc_i;
    end
  end

  // Cause is updated on the same edge as the sampled pcs,
  // so the pair selects a consistent dpc
  assign use_retire_pc = (cause_i == CAUSE_TRIGGER) || (cause_i == CAUSE_EBREAK);

  // Trigger and ebreak do not execute, so dpc points at them
  assign dpc_o       = use_retire_pc ? last_pc_q : last_next_pc_q;
  assign ebreak_pc_o = ebreak_pc_q;

endmodule

// File: logic/entry_detector.sv
// Detector of the first retirement in debug mode
module entry_detector (
  input  logic cov_assert_if,
  input  logic arst_n_i,
  input  logic debug_mode_i,
  input  logic id_valid_i,
  input  logic retire_i,
  output logic first_debug_o,
  output logic decoded_in_debug_o
);

  import debug_monitor_pkg::*;

  logic decoded_q;
  logic retired_q;

  // --------------------------------------------------
  // Debug-mode progress flags
  // --------------------------------------------------
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      decoded_q <= 1'b0;
      retired_q <= 1'b0;
    end else if (debug_mode_i) begin
      if (id_valid_i) begin
        decoded_q <= 1'b1;
      end
      if (retire_i) begin
        retired_q <= 1'b1;
      end
    end else begin
      // Leaving debug mode rearms detection
      decoded_q <= 1'b0;
      retired_q <= 1'b0;
    end
  end

  // Retirements left over from before entry are not debug code
  assign first_debug_o      = debug_mode_i && retire_i && !retired_q && decoded_q;
  assign decoded_in_debug_o = decoded_q;

endmodule

// File: logic/retire_decoder.sv
// Retirement classifier and trigger address comparator
module retire_decoder (
  input  logic                                wb_valid_i,
  input  logic                                wb_err_i,
  input  logic [debug_monitor_pkg::XLEN-1:0]  wb_instr_i,
  input  logic [debug_monitor_pkg::XLEN-1:0]  wb_pc_i,
  input  logic [debug_monitor_pkg::XLEN-1:0]  trig_addr_i,
  input  logic                                trig_en_i,
  output logic                                retire_o,
  output debug_monitor_pkg::instr_class_e     instr_class_o,
  output logic                                trig_hit_o
);

  import debug_monitor_pkg::*;

  logic [XLEN-1:0] trig_addr_aligned;
  logic            pc_match;

  // Only error-free retirements count
  assign retire_o = wb_valid_i && !wb_err_i;

  // --------------------------------------------------
  // Instruction class
  // --------------------------------------------------
  always_comb begin
    if (wb_instr_i == EBREAK_OPCODE) begin
      instr_class_o = INSTR_EBREAK;
    end else if (wb_instr_i == CEBREAK_OPCODE) begin
      instr_class_o = INSTR_CEBREAK;
    end else if (wb_instr_i == WFI_OPCODE) begin
      instr_class_o = INSTR_WFI;
    end else if (wb_instr_i == DRET_OPCODE) begin
      instr_class_o = INSTR_DRET;
    end else begin
      instr_class_o = INSTR_OTHER;
    end
  end

  // --------------------------------------------------
  // Trigger match
  // --------------------------------------------------
  assign trig_addr_aligned = {trig_addr_i[XLEN-1:PC_ALIGN_BITS], {PC_ALIGN_BITS{1'b0}}};
  assign pc_match          = (wb_pc_i == trig_addr_aligned);

  // Address match alone is not enough, trigger must be enabled
  assign trig_hit_o = retire_o && trig_en_i && pc_match;

endmodule

// File: logic/wb_status_regs.sv
// Wishbone classic slave with control, trigger and entry status registers
module wb_status_regs (
  input  logic                                cov_assert_if,
  input  logic                                arst_n_i,
  input  logic                                wbs_cyc_i,
  input  logic                                wbs_stb_i,
  input  logic                                wbs_we_i,
  input  logic [2:0]                          wbs_adr_i,
  input  logic [debug_monitor_pkg::XLEN-1:0]  wbs_dat_i,
  input  logic                                first_debug_i,
  input  debug_monitor_pkg::dbg_cause_e       cause_i,
  input  logic [debug_monitor_pkg::XLEN-1:0]  dpc_i,
  input  logic [debug_monitor_pkg::XLEN-1:0]  ebreak_pc_i,
  output logic [debug_monitor_pkg::XLEN-1:0]  wbs_dat_o,
  output logic                                wbs_ack_o,
  output logic                                trig_en_o,
  output logic                                ebreakm_o,
  output logic                                step_o,
  output logic [debug_monitor_pkg::XLEN-1:0]  trig_addr_o
);

  import debug_monitor_pkg::*;

  logic                   bus_req;
  logic                   ack_q;
  logic [XLEN-1:0]        rd_data;
  logic [XLEN-1:0]        dat_q;
  logic                   trig_en_q;
  logic                   ebreakm_q;
  logic                   step_q;
  logic [XLEN-1:0]        trig_addr_q;
  dbg_cause_e             entered_cause_q;
  logic [XLEN-1:0]        entered_dpc_q;
  logic [ENTRY_CNT_W-1:0] entry_cnt_q;

  // One-cycle ack, never stalls
  assign bus_req = wbs_cyc_i && wbs_stb_i && !ack_q;

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  always_comb begin
    rd_data = '0;
    case (wbs_adr_i)
      REG_CTRL: begin
        rd_data[CTRL_TRIG_EN_POS] = trig_en_q;
        rd_data[CTRL_EBREAKM_POS] = ebreakm_q;
        rd_data[CTRL_STEP_POS]    = step_q;
      end
      REG_TRIG_ADDR: rd_data = trig_addr_q;
      REG_STATUS: begin
        rd_data[2:0]                          = entered_cause_q;
        rd_data[STATUS_CNT_LSB +: ENTRY_CNT_W] = entry_cnt_q;
      end
      REG_DPC:       rd_data = entered_dpc_q;
      REG_EBREAK_PC: rd_data = ebreak_pc_i;
      default:       rd_data = '0;
    endcase
  end

  // --------------------------------------------------
  // Bus handshake and host-written registers
  // --------------------------------------------------
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q       <= 1'b0;
      dat_q       <= '0;
      trig_en_q   <= 1'b0;
      ebreakm_q   <= 1'b0;
      step_q      <= 1'b0;
      trig_addr_q <= '0;
    end else begin
      ack_q <= bus_req;
      if (bus_req) begin
        dat_q <= rd_data;
      end
      if (bus_req && wbs_we_i) begin
        case (wbs_adr_i)
          REG_CTRL: begin
            trig_en_q <= wbs_dat_i[CTRL_TRIG_EN_POS];
            ebreakm_q <= wbs_dat_i[CTRL_EBREAKM_POS];
            step_q    <= wbs_dat_i[CTRL_STEP_POS];
          end
          // Trigger compares word addresses only
          REG_TRIG_ADDR: trig_addr_q <= {wbs_dat_i[XLEN-1:PC_ALIGN_BITS], {PC_ALIGN_BITS{1'b0}}};
          default: ;
        endcase
      end
    end
  end

  // Entry results, latched on the first debug retirement
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      entered_cause_q <= CAUSE_NONE;
      entered_dpc_q   <= '0;
      entry_cnt_q     <= '0;
    end else if (first_debug_i) begin
      entered_cause_q <= cause_i;
      entered_dpc_q   <= dpc_i;
      entry_cnt_q     <= entry_cnt_q + 1'b1;
    end
  end

  assign wbs_ack_o   = ack_q;
  assign wbs_dat_o   = dat_q;
  assign trig_en_o   = trig_en_q;
  assign ebreakm_o   = ebreakm_q;
  assign step_o      = step_q;
  assign trig_addr_o = trig_addr_q;

endmodule
